/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_wasm_ctrl
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^TEST OK$$"

clean:
	rm -rf $(OBJ_DIR)

/* sources.f */
verilog/wasm_pkg.sv
verilog/leb128_decode.sv
verilog/entry_table.sv
verilog/opcode_decode.sv
verilog/return_stack.sv
verilog/module_parser.sv
verilog/wasm_ctrl_top.sv
verification/wasm_ctrl_sva.sv
verification/tb_wasm_ctrl.sv

/* verification/tb_wasm_ctrl.sv */
// clock, reset, byte-memory fetch model, module programs and output checks
`timescale 1ns/1ns

module tb_wasm_ctrl import wasm_pkg::*; ();

    localparam int mem_size = 4096;
    localparam logic [7:0] bin_opc [19] = '{
        8'h46, 8'h47, 8'h48, 8'h49, 8'h4a, 8'h4b, 8'h4c, 8'h4d, 8'h4e, 8'h4f,
        8'h6a, 8'h6b, 8'h71, 8'h72, 8'h74, 8'h75, 8'h76, 8'h77, 8'h78
    };
    localparam logic [4:0] bin_code [19] = '{
        5'd6, 5'd15, 5'd11, 5'd7, 5'd12, 5'd8, 5'd13, 5'd9, 5'd14, 5'd10,
        5'd0, 5'd1, 5'd2, 5'd3, 5'd16, 5'd17, 5'd18, 5'd19, 5'd20
    };

    logic                      clk;
    logic                      rst_n;
    logic [addr_w-1:0]         read_pointer;
    logic [window_bytes*8-1:0] window;
    logic [7:0]                advance;
    logic                      jump_en;
    logic [addr_w-1:0]         jump_addr;
    stack_ctrl_t               stack_ctrl;
    logic [31:0]               imm;
    logic                      call_en;
    call_frame_t               call_frame;
    logic                      ret_en;
    logic                      finish;
    logic                      instr_error;

    logic [7:0]        mem [mem_size];
    bit                exp_on [mem_size];
    stack_ctrl_t       exp_ctrl [mem_size];
    logic [7:0]        exp_len [mem_size];
    bit                exp_has_imm [mem_size];
    logic [31:0]       exp_imm [mem_size];
    logic [addr_w-1:0] next_ptr;
    integer            seed;
    int                errors;
    int                timeouts;
    int                wp;
    int                f0_entry;
    int                f1_entry;
    int                f0_end;
    int                call_site;

    wasm_ctrl_top dut0 (
        .clk, .rst_n, .read_pointer, .window, .advance, .jump_en, .jump_addr, .stack_ctrl,
        .imm, .call_en, .call_frame, .ret_en, .finish, .instr_error
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expv,
                               input logic [31:0] actv);
        assert (actv === expv) else begin
            $display("Mismatch at %0t ns: %s expected %0h actual %0h", $time, name, expv, actv);
            errors++;
        end
    endtask

    // pointer and window change on the falling edge and the decision is sampled before the rising edge
    task automatic step(input bit rst_val);
        logic [addr_w-1:0] a;
        @(negedge clk);
        rst_n        = rst_val;
        read_pointer = rst_val ? next_ptr : '0;
        for (int i = 0; i < window_bytes; i++) begin
            a = read_pointer + addr_w'(i);
            window[i*8 +: 8] = mem[a];
        end
        #2;
        if (!rst_n) begin
            next_ptr = '0;
        end else if (jump_en) begin
            next_ptr = jump_addr;
        end else begin
            next_ptr = read_pointer + addr_w'(advance);
        end
    endtask

    task automatic reset_dut();
        next_ptr = '0;
        repeat (4) begin
            step(1'b0);
            check_value("reset outputs", 32'd0,
                        32'({jump_en, call_en, ret_en, finish, instr_error, stack_ctrl}));
        end
    endtask

    task automatic clear_mem();
        for (int i = 0; i < mem_size; i++) begin
            mem[i]    = 8'(i ^ (i >> 5) ^ (i >> 9)); // address-dependent fill
            exp_on[i] = 1'b0;
        end
        wp = 0;
    endtask

    task automatic put(input logic [7:0] b);
        mem[wp] = b;
        wp++;
    endtask

    task automatic put_bytes(input logic [63:0] v, input int n);
        for (int i = 0; i < n; i++) begin
            put(v[i*8 +: 8]);
        end
    endtask

    // two-byte padded LEB128 so sizes can be filled in later
    task automatic patch_size(input int at, input int v);
        mem[at]     = 8'h80 | 8'(v & 'h7f);
        mem[at + 1] = 8'((v >> 7) & 'h7f);
    endtask

    function automatic stack_ctrl_t mk_ctrl(input logic push, input logic [3:0] pop,
                                            input push_src_e src, input logic [4:0] code);
        stack_ctrl_t c;
        c.push_num = push;
        c.pop_num  = pop;
        c.push_src = src;
        c.alu_op   = alu_op_e'(code);
        return c;
    endfunction

    task automatic emit(input logic [7:0] opc, input stack_ctrl_t c, input int len);
        exp_on[wp]      = 1'b1;
        exp_ctrl[wp]    = c;
        exp_len[wp]     = 8'(len);
        exp_has_imm[wp] = 1'b0;
        put(opc);
    endtask

    task automatic emit_const(input int n);
        logic [31:0] v;
        v = $random(seed);
        if (n < 5) begin
            v = v & ((32'd1 << (7 * n)) - 32'd1);
        end
        v = v | (32'd1 << (7 * (n - 1))); // top group nonzero, exactly n bytes
        emit(8'h41, mk_ctrl(1'b1, 4'd0, src_imm, 5'd0), 1 + n);
        exp_has_imm[wp-1] = 1'b1;
        exp_imm[wp-1]     = v;
        for (int i = 0; i < n; i++) begin
            put(8'((v >> (7 * i)) & 32'h7f) | ((i < n - 1) ? 8'h80 : 8'h00));
        end
    endtask

    task automatic build_module(input bit trap);
        int sec_slot;
        int sec_base;
        int body_slot;
        clear_mem();
        call_site = -1;
        put_bytes(64'h0000_0001_6d73_6100, 8);
        put_bytes(64'hcc_bbaa_0300, 5);         // custom section to be skipped
        put(8'h01);
        sec_slot = wp;
        put_bytes(64'h0, 2);
        sec_base = wp;
        put_bytes(64'h00_7f01_6002, 5);          // two sigs then (i32) -> ()
        put_bytes(64'h7f01_7f7f_0260, 6);        // (i32 i32) -> i32
        patch_size(sec_slot, wp - sec_base);
        put_bytes(64'h01_0108, 3);               // start = function 1
        put(8'h0a);
        sec_slot = wp;
        put_bytes(64'h0, 2);
        sec_base = wp;
        put(8'h02);
        body_slot = wp;
        put_bytes(64'h0, 2);
        put_bytes(64'h7f_0201, 3);               // 2 locals
        f0_entry = wp;
        emit(8'h01, '0, 1);
        f0_end = wp;
        emit(8'h0b, '0, 1);
        patch_size(body_slot, wp - body_slot - 2);
        body_slot = wp;
        put_bytes(64'h0, 2);
        put_bytes(64'h7f03_7f01_02, 5);          // 1 + 3 locals
        f1_entry = wp;
        if (trap) begin
            emit_const(3);
            emit(8'h00, '0, 1);
        end else begin
            emit(8'h01, '0, 1);
            for (int k = 0; k < 8; k++) begin
                emit_const((k < 5) ? k + 1 : 1 + int'($unsigned($random(seed)) % 5));
            end
            for (int k = 0; k < 19; k++) begin
                emit(bin_opc[k], mk_ctrl(1'b1, 4'd2, src_alu, bin_code[k]), 1);
            end
            emit(8'h45, mk_ctrl(1'b1, 4'd1, src_alu, 5'd5), 1);
            emit(8'h1a, mk_ctrl(1'b0, 4'd1, src_alu, 5'd0), 1);
            emit(8'h20, mk_ctrl(1'b1, 4'd0, src_local, 5'd0), 2);
            put(8'h00);
            emit(8'h21, mk_ctrl(1'b0, 4'd1, src_alu, 5'd0), 2);
            put(8'h01);
            emit(8'h22, '0, 2);
            put(8'h02);
            call_site = wp;
            emit(8'h10, '0, 2);
            put(8'h00);
        end
        emit(8'h0b, '0, 1);
        patch_size(body_slot, wp - body_slot - 2);
        patch_size(sec_slot, wp - sec_base);
    endtask

    task automatic run_program(input bit trap);
        bit launched;
        bit done;
        int launches;
        int calls;
        int rets;
        int ptr;
        launched = 1'b0;
        done     = 1'b0;
        launches = 0;
        calls    = 0;
        rets     = 0;
        for (int cyc = 0; cyc < 2000 && !done; cyc++) begin
            step(1'b1);
            ptr = int'(read_pointer);
            if (finish || instr_error) begin
                done = 1'b1;
            end else if (!launched) begin
                check_value("stack_ctrl before launch", 32'd0, 32'(stack_ctrl));
                if (call_en) begin
                    launched = 1'b1;
                    launches++;
                    check_value("jump_en", 32'd1, 32'(jump_en));
                    check_value("jump_addr", 32'(f1_entry), 32'(jump_addr));
                    check_value("call_frame.local_size", 32'd4, 32'(call_frame.local_size));
                    check_value("call_frame.param_num", 32'd2, 32'(call_frame.sig.param_num));
                    check_value("call_frame.result_num", 32'd1,
                                32'(call_frame.sig.result_num));
                end
            end else begin
                check_value("call_en", 32'(ptr == call_site), 32'(call_en));
                check_value("ret_en", 32'(ptr == f0_end), 32'(ret_en));
                check_value("jump_en", 32'(ptr == call_site || ptr == f0_end), 32'(jump_en));
                if (exp_on[ptr]) begin
                    check_value("stack_ctrl", 32'(exp_ctrl[ptr]), 32'(stack_ctrl));
                    if (exp_has_imm[ptr]) begin
                        check_value("imm", exp_imm[ptr], imm);
                    end
                    if (!jump_en) begin
                        check_value("advance", 32'(exp_len[ptr]), 32'(advance));
                    end
                end
                if (ptr == call_site) begin
                    calls++;
                    check_value("jump_addr", 32'(f0_entry), 32'(jump_addr));
                    check_value("call_frame.ret_addr", 32'(call_site + 2),
                                32'(call_frame.ret_addr));
                end
                if (ptr == f0_end) begin
                    rets++;
                    check_value("jump_addr", 32'(call_site + 2), 32'(jump_addr));
                end
            end
        end
        if (!done) begin
            $display("timeout: program did not finish within 2000 cycles");
            timeouts++;
        end
        check_value("launch count", 32'd1, 32'(launches));
        check_value("finish", 32'd1, 32'(finish));
        check_value("instr_error", 32'(trap), 32'(instr_error));
        if (!trap) begin
            check_value("call count", 32'd1, 32'(calls));
            check_value("return count", 32'd1, 32'(rets));
        end
    endtask

    task automatic run_bad_magic();
        bit seen;
        clear_mem();
        put_bytes(64'h0000_0002_6d73_6100, 8); // version 2
        reset_dut();
        seen = 1'b0;
        for (int cyc = 0; cyc < 50 && !seen; cyc++) begin
            step(1'b1);
            check_value("finish", 32'd0, 32'(finish));
            check_value("stack_ctrl", 32'd0, 32'(stack_ctrl));
            seen = instr_error;
        end
        if (!seen) begin
            $display("timeout: instr_error not raised for a bad header");
            timeouts++;
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        read_pointer = '0;
        window       = '0;
        next_ptr     = '0;
        seed         = 88;
        errors       = 0;
        timeouts     = 0;
        run_bad_magic();
        build_module(1'b0);
        reset_dut();
        run_program(1'b0);
        build_module(1'b1);
        reset_dut();
        run_program(1'b1);
        $display("mismatches: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verification/wasm_ctrl_sva.sv */
// concurrent checks on control unit outputs bound into the top level
`timescale 1ns/1ns

module wasm_ctrl_sva import wasm_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input stack_ctrl_t stack_ctrl,
    input logic        body_run,
    input logic        call_en,
    input logic        ret_en,
    input logic        jump_en,
    input logic        finish,
    input logic        instr_error
);

    // both status flags hold until reset
    finish_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) finish |=> finish
    ) else $error("finish dropped while out of reset");

    error_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) instr_error |=> instr_error
    ) else $error("instr_error dropped while out of reset");

    ctrl_only_in_run: assert property (
        @(posedge clk) disable iff (!rst_n) !body_run |-> (stack_ctrl == '0)
    ) else $error("stack controls issued outside the body-run state");

    call_ret_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(call_en && ret_en)
    ) else $error("call_en and ret_en high in the same cycle");

    no_jump_after_finish: assert property (
        @(posedge clk) disable iff (!rst_n) finish |-> !jump_en
    ) else $error("jump requested after finish");

endmodule

bind wasm_ctrl_top wasm_ctrl_sva sva0 (.*);

/* verilog/entry_table.sv */
// indexed register table with one write port and one combinational read port
`timescale 1ns/1ns

module entry_table import wasm_pkg::*; #(
    parameter type entry_t = sig_t
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  logic [func_idx_w-1:0] wr_idx,
    input  entry_t                wr_data,
    input  logic [func_idx_w-1:0] rd_idx,
    output entry_t                rd_data
);

    entry_t mem [func_max];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < func_max; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    assign rd_data = mem[rd_idx];

endmodule

/* verilog/leb128_decode.sv */
// unsigned 32-bit LEB128 decoder with byte count
`timescale 1ns/1ns

module leb128_decode import wasm_pkg::*; (
    input  logic [window_bytes*8-1:0] bytes,
    output logic [31:0]               value,
    output logic [2:0]                byte_cnt
);

    logic done;

    always_comb begin
        value    = '0;
        byte_cnt = 3'd5; // no terminator within five bytes
        done     = 1'b0;
        for (int i = 0; i < 5; i++) begin
            if (!done) begin
                value = value | (32'(bytes[i*8 +: 7]) << (7 * i));
                if (!bytes[i*8+7]) begin
                    byte_cnt = 3'(i + 1);
                    done     = 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/module_parser.sv */
// module header, section walk, code pre-read and body-run FSM with jump and finish logic
`timescale 1ns/1ns

module module_parser import wasm_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [addr_w-1:0]         read_pointer,
    input  logic [window_bytes*8-1:0] window,
    input  logic [31:0]               leb_value,
    input  logic [2:0]                leb_cnt,
    input  logic [7:0]                op_len,
    input  sig_t                      sig_rd,
    input  func_entry_t               entry_rd,
    input  logic [addr_w-1:0]         ret_top,
    input  logic                      ret_last,
    output logic                      sig_wr_en,
    output logic                      entry_wr_en,
    output logic [func_idx_w-1:0]     tbl_wr_idx,
    output sig_t                      sig_wr,
    output func_entry_t               entry_wr,
    output logic [func_idx_w-1:0]     tbl_rd_idx,
    output logic [7:0]                advance,
    output logic                      jump_en,
    output logic [addr_w-1:0]         jump_addr,
    output logic                      body_run,
    output logic                      call_en,
    output call_frame_t               call_frame,
    output logic                      ret_en,
    output logic                      finish,
    output logic                      instr_error
);

    typedef enum logic [3:0] {
        st_header, st_sec_head, st_sec_size, st_vec_head, st_type_par,
        st_type_res, st_code_len, st_code_decl, st_code_loc, st_run
    } state_e;

    state_e                state;
    logic                  finish_q;
    logic                  error_q;
    logic [func_idx_w-1:0] vec_cnt;
    logic [func_idx_w-1:0] vec_last;
    logic [func_idx_w-1:0] start_idx;
    logic [7:0]            sec_id;
    logic [3:0]            param_q;
    logic [addr_w-1:0]     body_end;
    logic [7:0]            decl_num;
    logic [7:0]            decl_cnt;
    logic [7:0]            local_acc;
    logic                  halted;
    logic                  known;
    logic                  locals_done;
    logic [7:0]            opcode;
    logic [addr_w-1:0]     leb_end;

    assign halted      = finish_q | error_q;
    assign known       = (sec_id == sec_type) | (sec_id == sec_start) | (sec_id == sec_code);
    assign locals_done = (decl_cnt == decl_num);
    assign opcode      = window[7:0];
    assign leb_end     = read_pointer + addr_w'(leb_cnt) + addr_w'(leb_value);

    assign tbl_wr_idx  = vec_cnt;
    assign sig_wr      = '{param_num: param_q, result_num: window[0]};
    assign entry_wr    = '{entry_addr: read_pointer, local_size: local_acc};
    assign body_run    = (state == st_run) && !halted;
    assign finish      = finish_q;
    assign instr_error = error_q;

    always_comb begin
        advance             = 8'd0;
        jump_en             = 1'b0;
        jump_addr           = '0;
        call_en             = 1'b0;
        ret_en              = 1'b0;
        sig_wr_en           = 1'b0;
        entry_wr_en         = 1'b0;
        tbl_rd_idx          = start_idx;
        call_frame.sig      = sig_rd;
        call_frame.local_size = entry_rd.local_size;
        call_frame.ret_addr = '0;
        if (!halted) begin
            case (state)
                st_header:   advance = (window[63:0] == wasm_magic_version) ? 8'd8 : 8'd0;
                st_sec_head: advance = 8'd1; // id byte
                st_sec_size: begin
                    if (known) begin
                        advance = 8'(leb_cnt);
                    end else begin
                        jump_en   = 1'b1;
                        jump_addr = leb_end;
                    end
                end
                st_vec_head, st_code_len, st_code_decl: advance = 8'(leb_cnt);
                st_type_par: advance = 8'd2 + window[15:8]; // form byte, count, params
                st_type_res: begin
                    advance   = 8'd1 + window[7:0];
                    sig_wr_en = 1'b1;
                end
                st_code_loc: begin
                    if (locals_done) begin
                        entry_wr_en = 1'b1;
                        jump_en     = 1'b1;
                        jump_addr   = body_end;
                        if (vec_cnt == vec_last) begin // launch start function
                            call_en = 1'b1;
                            if (start_idx == vec_cnt) begin
                                jump_addr             = read_pointer;
                                call_frame.local_size = local_acc;
                            end else begin
                                jump_addr = entry_rd.entry_addr;
                            end
                        end
                    end else begin
                        advance = 8'(leb_cnt) + 8'd1; // count plus valtype
                    end
                end
                st_run: begin
                    advance    = op_len;
                    tbl_rd_idx = leb_value[func_idx_w-1:0];
                    if (opcode == op_call) begin
                        call_en             = 1'b1;
                        jump_en             = 1'b1;
                        jump_addr           = entry_rd.entry_addr;
                        call_frame.ret_addr = read_pointer + addr_w'(op_len);
                    end else if (opcode == op_end && !ret_last) begin
                        ret_en    = 1'b1;
                        jump_en   = 1'b1;
                        jump_addr = ret_top;
                    end
                end
                default: advance = 8'd0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_header;
            finish_q  <= 1'b0;
            error_q   <= 1'b0;
            vec_cnt   <= '0;
            start_idx <= '0;
        end else if (!halted) begin
            case (state)
                st_header: begin
                    if (window[63:0] == wasm_magic_version) begin
                        state <= st_sec_head;
                    end else begin
                        error_q <= 1'b1;
                    end
                end
                st_sec_head: state <= st_sec_size;
                st_sec_size: state <= known ? st_vec_head : st_sec_head;
                st_vec_head: begin
                    vec_cnt <= '0;
                    if (sec_id == sec_type) begin
                        state <= st_type_par;
                    end else if (sec_id == sec_code) begin
                        state <= st_code_len;
                    end else begin
                        start_idx <= leb_value[func_idx_w-1:0]; // start section
                        state     <= st_sec_head;
                    end
                end
                st_type_par: state <= st_type_res;
                st_type_res: begin
                    vec_cnt <= vec_cnt + 1'b1;
                    state   <= (vec_cnt == vec_last) ? st_sec_head : st_type_par;
                end
                st_code_len:  state <= st_code_decl;
                st_code_decl: state <= st_code_loc;
                st_code_loc: begin
                    if (locals_done) begin
                        vec_cnt <= vec_cnt + 1'b1;
                        state   <= (vec_cnt == vec_last) ? st_run : st_code_len;
                    end
                end
                st_run: begin
                    if (opcode == op_unreachable) begin
                        error_q  <= 1'b1;
                        finish_q <= 1'b1;
                    end else if (opcode == op_end && ret_last) begin
                        finish_q <= 1'b1;
                    end
                end
                default: state <= st_header;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_sec_head: sec_id <= window[7:0];
            st_vec_head: vec_last <= func_idx_w'(leb_value - 32'd1);
            st_type_par: param_q <= window[11:8];
            st_code_len: begin
                body_end  <= leb_end;
                local_acc <= '0;
            end
            st_code_decl: begin
                decl_num <= leb_value[7:0];
                decl_cnt <= '0;
            end
            st_code_loc: begin
                decl_cnt  <= decl_cnt + 8'd1;
                local_acc <= local_acc + leb_value[7:0];
            end
            default: decl_cnt <= decl_cnt;
        endcase
    end

endmodule

/* verilog/opcode_decode.sv */
// opcode to stack controls, alu code and instruction length
`timescale 1ns/1ns

module opcode_decode import wasm_pkg::*; (
    input  logic [7:0]  opcode,
    input  logic [2:0]  leb_cnt,
    output stack_ctrl_t ctrl,
    output logic [7:0]  length
);

    logic    is_bin;
    alu_op_e bin_code;

    // two-operand ops pop 2 and push 1
    always_comb begin
        is_bin   = 1'b1;
        bin_code = alu_add;
        case (opcode)
            op_i32_eq:    bin_code = alu_eq;
            op_i32_ne:    bin_code = alu_ne;
            op_i32_lt_s:  bin_code = alu_lt_s;
            op_i32_lt_u:  bin_code = alu_lt_u;
            op_i32_gt_s:  bin_code = alu_gt_s;
            op_i32_gt_u:  bin_code = alu_gt_u;
            op_i32_le_s:  bin_code = alu_le_s;
            op_i32_le_u:  bin_code = alu_le_u;
            op_i32_ge_s:  bin_code = alu_ge_s;
            op_i32_ge_u:  bin_code = alu_ge_u;
            op_i32_add:   bin_code = alu_add;
            op_i32_sub:   bin_code = alu_sub;
            op_i32_and:   bin_code = alu_and;
            op_i32_or:    bin_code = alu_or;
            op_i32_shl:   bin_code = alu_shl;
            op_i32_shr_s: bin_code = alu_shrs;
            op_i32_shr_u: bin_code = alu_shru;
            op_i32_rotl:  bin_code = alu_rotl;
            op_i32_rotr:  bin_code = alu_rotr;
            default:      is_bin   = 1'b0;
        endcase
    end

    always_comb begin
        ctrl   = '0;
        length = 8'd1;
        case (opcode)
            op_nop:  length = 8'd1; // no stack effect
            op_drop: ctrl.pop_num = 4'd1;
            op_i32_eqz: begin
                ctrl.pop_num  = 4'd1;
                ctrl.push_num = 1'b1;
                ctrl.alu_op   = alu_eqz;
            end
            op_i32_const: begin
                ctrl.push_num = 1'b1;
                ctrl.push_src = src_imm;
                length        = 8'd1 + 8'(leb_cnt);
            end
            op_local_get: begin
                ctrl.push_num = 1'b1;
                ctrl.push_src = src_local;
                length        = 8'd1 + 8'(leb_cnt);
            end
            op_local_set: begin
                ctrl.pop_num = 4'd1;
                length       = 8'd1 + 8'(leb_cnt);
            end
            op_local_tee, op_call: length = 8'd1 + 8'(leb_cnt); // index operand only
            default: begin
                if (is_bin) begin
                    ctrl.pop_num  = 4'd2;
                    ctrl.push_num = 1'b1;
                    ctrl.alu_op   = bin_code;
                end
            end
        endcase
    end

endmodule

/* verilog/return_stack.sv */
// return-address stack for call and end
`timescale 1ns/1ns

module return_stack import wasm_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  logic [addr_w-1:0] push_addr,
    input  logic              pop,
    output logic [addr_w-1:0] top_addr,
    output logic              last_frame
);

    logic [addr_w-1:0]    stk [stack_depth];
    logic [ret_ptr_w-1:0] depth;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            depth <= '0;
        end else if (push) begin
            depth <= depth + 1'b1;
        end else if (pop) begin
            depth <= depth - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            stk[depth[ret_ptr_w-2:0]] <= push_addr;
        end
    end

    assign top_addr   = stk[(ret_ptr_w-1)'(depth - 1'b1)];
    assign last_frame = (depth == ret_ptr_w'(1)); // only the start frame left

endmodule

/* verilog/wasm_ctrl_top.sv */
// control unit top level with LEB128 decoders, opcode decoder, tables, return stack and parser
`timescale 1ns/1ns

module wasm_ctrl_top import wasm_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [addr_w-1:0]         read_pointer,
    input  logic [window_bytes*8-1:0] window,
    output logic [7:0]                advance,
    output logic                      jump_en,
    output logic [addr_w-1:0]         jump_addr,
    output stack_ctrl_t               stack_ctrl,
    output logic [31:0]               imm,
    output logic                      call_en,
    output call_frame_t               call_frame,
    output logic                      ret_en,
    output logic                      finish,
    output logic                      instr_error
);

    logic [31:0]           op_value;
    logic [2:0]            op_cnt;
    logic [31:0]           hd_value;
    logic [2:0]            hd_cnt;
    stack_ctrl_t           dec_ctrl;
    logic [7:0]            op_len;
    logic                  body_run;
    logic                  sig_wr_en;
    logic                  entry_wr_en;
    logic [func_idx_w-1:0] tbl_wr_idx;
    logic [func_idx_w-1:0] tbl_rd_idx;
    sig_t                  sig_wr;
    sig_t                  sig_rd;
    func_entry_t           entry_wr;
    func_entry_t           entry_rd;
    logic [addr_w-1:0]     ret_top;
    logic                  ret_last;

    leb128_decode leb_op (
        .bytes({8'h00, window[window_bytes*8-1:8]}), .value(op_value), .byte_cnt(op_cnt)
    );
    leb128_decode leb_hd (.bytes(window), .value(hd_value), .byte_cnt(hd_cnt));

    opcode_decode u_dec (.opcode(window[7:0]), .leb_cnt(op_cnt), .ctrl(dec_ctrl), .length(op_len));

    entry_table #(.entry_t(sig_t)) sig_tab (
        .clk, .rst_n, .wr_en(sig_wr_en), .wr_idx(tbl_wr_idx), .wr_data(sig_wr),
        .rd_idx(tbl_rd_idx), .rd_data(sig_rd)
    );
    entry_table #(.entry_t(func_entry_t)) func_tab (
        .clk, .rst_n, .wr_en(entry_wr_en), .wr_idx(tbl_wr_idx), .wr_data(entry_wr),
        .rd_idx(tbl_rd_idx), .rd_data(entry_rd)
    );

    return_stack u_ret (
        .clk, .rst_n, .push(call_en), .push_addr(call_frame.ret_addr), .pop(ret_en),
        .top_addr(ret_top), .last_frame(ret_last)
    );

    module_parser u_parser (
        .clk, .rst_n, .read_pointer, .window,
        .leb_value(body_run ? op_value : hd_value), // operand after opcode while running
        .leb_cnt(body_run ? op_cnt : hd_cnt),
        .op_len, .sig_rd, .entry_rd, .ret_top, .ret_last,
        .sig_wr_en, .entry_wr_en, .tbl_wr_idx, .sig_wr, .entry_wr, .tbl_rd_idx,
        .advance, .jump_en, .jump_addr, .body_run, .call_en, .call_frame, .ret_en,
        .finish, .instr_error
    );

    assign stack_ctrl = body_run ? dec_ctrl : '0;
    assign imm        = op_value;

endmodule

/* verilog/wasm_pkg.sv */
// sizes, module header value, section ids, opcodes, alu codes and shared structs
package wasm_pkg;

    localparam int addr_w       = 12;
    localparam int window_bytes = 8;
    localparam int func_max     = 16;
    localparam int stack_depth  = 8;
    localparam int func_idx_w   = $clog2(func_max);
    localparam int ret_ptr_w    = $clog2(stack_depth) + 1;

    // "\0asm" then version 1 with byte 0 in the low bits
    localparam logic [63:0] wasm_magic_version = 64'h0000_0001_6d73_6100;

    localparam logic [7:0] sec_type  = 8'h01;
    localparam logic [7:0] sec_start = 8'h08;
    localparam logic [7:0] sec_code  = 8'h0a;

    localparam logic [7:0] op_unreachable = 8'h00;
    localparam logic [7:0] op_nop         = 8'h01;
    localparam logic [7:0] op_end         = 8'h0b;
    localparam logic [7:0] op_call        = 8'h10;
    localparam logic [7:0] op_drop        = 8'h1a;
    localparam logic [7:0] op_local_get   = 8'h20;
    localparam logic [7:0] op_local_set   = 8'h21;
    localparam logic [7:0] op_local_tee   = 8'h22;
    localparam logic [7:0] op_i32_const   = 8'h41;
    localparam logic [7:0] op_i32_eqz     = 8'h45;
    localparam logic [7:0] op_i32_eq      = 8'h46;
    localparam logic [7:0] op_i32_ne      = 8'h47;
    localparam logic [7:0] op_i32_lt_s    = 8'h48;
    localparam logic [7:0] op_i32_lt_u    = 8'h49;
    localparam logic [7:0] op_i32_gt_s    = 8'h4a;
    localparam logic [7:0] op_i32_gt_u    = 8'h4b;
    localparam logic [7:0] op_i32_le_s    = 8'h4c;
    localparam logic [7:0] op_i32_le_u    = 8'h4d;
    localparam logic [7:0] op_i32_ge_s    = 8'h4e;
    localparam logic [7:0] op_i32_ge_u    = 8'h4f;
    localparam logic [7:0] op_i32_add     = 8'h6a;
    localparam logic [7:0] op_i32_sub     = 8'h6b;
    localparam logic [7:0] op_i32_and     = 8'h71;
    localparam logic [7:0] op_i32_or      = 8'h72;
    localparam logic [7:0] op_i32_shl     = 8'h74;
    localparam logic [7:0] op_i32_shr_s   = 8'h75;
    localparam logic [7:0] op_i32_shr_u   = 8'h76;
    localparam logic [7:0] op_i32_rotl    = 8'h77;
    localparam logic [7:0] op_i32_rotr    = 8'h78;

    typedef enum logic [4:0] {
        alu_add  = 5'd0,
        alu_sub  = 5'd1,
        alu_and  = 5'd2,
        alu_or   = 5'd3,
        alu_eqz  = 5'd5, // code 4 unused
        alu_eq   = 5'd6,
        alu_lt_u = 5'd7,
        alu_gt_u = 5'd8,
        alu_le_u = 5'd9,
        alu_ge_u = 5'd10,
        alu_lt_s = 5'd11,
        alu_gt_s = 5'd12,
        alu_le_s = 5'd13,
        alu_ge_s = 5'd14,
        alu_ne   = 5'd15,
        alu_shl  = 5'd16,
        alu_shrs = 5'd17,
        alu_shru = 5'd18,
        alu_rotl = 5'd19,
        alu_rotr = 5'd20
    } alu_op_e;

    typedef enum logic [1:0] {
        src_alu   = 2'b00,
        src_imm   = 2'b10,
        src_local = 2'b11
    } push_src_e;

    typedef struct packed {
        logic       push_num;
        logic [3:0] pop_num;
        push_src_e  push_src;
        alu_op_e    alu_op;
    } stack_ctrl_t;

    typedef struct packed {
        logic [3:0] param_num;
        logic       result_num;
    } sig_t;

    typedef struct packed {
        logic [addr_w-1:0] entry_addr;
        logic [7:0]        local_size;
    } func_entry_t;

    typedef struct packed {
        sig_t              sig;
        logic [7:0]        local_size;
        logic [addr_w-1:0] ret_addr;
    } call_frame_t;

endpackage
